// File: common/gem_tx_pkg.sv
`default_nettype none

package gem_tx_pkg;

   // -------------------------------------------------------------------------
   // Trigger bundle and link word
   // -------------------------------------------------------------------------

   // One bundle per bunch crossing, as handed over by the cluster source
   typedef struct packed {
      logic [111:0] clusters;   // Link 1 in the upper half, link 0 in the lower
      logic         overflow;   // More than 8 clusters found
      logic         bc0;        // Bunch-crossing zero marker
      logic         resync;     // Resync marker
      logic [1:0]   bxn_lsbs;   // Low BX bits, drive the separator rotation
   } trig_bundle_t;

   typedef struct packed {
      logic [15:0] data;        // Two bytes per word
      logic [1:0]  isk;         // Char-is-K, one bit per byte
   } link_word_t;

   localparam int LINK_DATA_BITS = 56;   // Cluster bits carried per link
   localparam int FRAME_WORDS    = 4;    // Words per frame

   // Separator K-codes, priority bc0 > resync > overflow > rotation
   localparam logic [7:0] K_BC0      = 8'h1C;   // K.28.0
   localparam logic [7:0] K_RESYNC   = 8'h3C;   // K.28.1
   localparam logic [7:0] K_OVERFLOW = 8'hFE;   // K.30.7

   // Index 0..3 gives BC, F7, FB, FD
   localparam logic [3:0][7:0] K_SEQ = {8'hFD, 8'hFB, 8'hF7, 8'hBC};

   // Comma filler sent between frames
   localparam link_word_t IDLE_WORD = '{data: 16'hFFFC, isk: 2'b01};

endpackage

`default_nettype wire

// File: logic/cluster_capture.sv
`timescale 1ns/1ps
`default_nettype none

module cluster_capture (
   input  wire                       clock_40,
   input  wire                       rst_n_i,
   input  wire gem_tx_pkg::trig_bundle_t bundle_i,
   input  wire                       bundle_valid_i,
   output logic                      bundle_ready_o,
   input  wire                       link_up_i,
   input  wire                       full_i,          // From the bundle FIFO
   output gem_tx_pkg::trig_bundle_t  push_o,
   output logic                      wr_en_o
);

   logic                     hold_valid_q;   // Holding register occupied
   gem_tx_pkg::trig_bundle_t hold_q;         // Captured bundle
   logic                     accept;         // Handshake completes this cycle

   // Drain into the FIFO whenever it has room
   assign wr_en_o = hold_valid_q & ~full_i;
   assign push_o  = hold_q;

   // Room if empty or emptied this cycle, only while the link runs
   assign bundle_ready_o = link_up_i & (~hold_valid_q | wr_en_o);
   assign accept         = bundle_valid_i & bundle_ready_o;

   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hold_valid_q <= 1'b0;
      end else if (accept) begin
         hold_valid_q <= 1'b1;                // Refill wins over drain
      end else if (wr_en_o) begin
         hold_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clock_40) begin
      if (accept) hold_q <= bundle_i;
   end

endmodule

`default_nettype wire

// File: bundle_fifo/bundle_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  wire                       clock_40,
   input  wire                       rst_n_i,
   input  wire                       wr_en_i,
   input  wire gem_tx_pkg::trig_bundle_t wr_data_i,
   output logic                      full_o,
   input  wire                       rd_en_i,
   output gem_tx_pkg::trig_bundle_t  rd_data_o,
   output logic                      empty_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   gem_tx_pkg::trig_bundle_t mem [FIFO_DEPTH];   // Bundle storage

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;                     // Occupancy

   assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
   assign empty_o = (count_q == '0);

   // -------------------------------------------------------------------------
   // Pointers and occupancy
   // -------------------------------------------------------------------------

   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en_i)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (rd_en_i)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         case ({wr_en_i, rd_en_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;          // Idle or push and pop together
         endcase
      end
   end

   // Storage and registered read port
   always_ff @(posedge clock_40) begin
      if (wr_en_i) mem[wr_ptr_q] <= wr_data_i;
      if (rd_en_i) rd_data_o <= mem[rd_ptr_q];   // Valid the cycle after the pop
   end

endmodule

`default_nettype wire

// File: link_framer/link_framer.sv
`timescale 1ns/1ps
`default_nettype none

module link_framer #(
   parameter int N_LINKS = 2
) (
   input  wire                       clock_40,
   input  wire                       rst_n_i,
   input  wire                       link_up_i,
   input  wire                       empty_i,
   output logic                      rd_en_o,
   input  wire gem_tx_pkg::trig_bundle_t rd_data_i,
   output wire gem_tx_pkg::link_word_t [N_LINKS-1:0] tx_words_o
);

   localparam int SLOT_W = $clog2(gem_tx_pkg::FRAME_WORDS);
   localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(gem_tx_pkg::FRAME_WORDS - 1);

   logic              run_q;     // Frame words are being loaded
   logic [SLOT_W-1:0] slot_q;    // Word loaded into the output registers now
   logic [7:0]        sep;       // Separator for the bundle on rd_data_i

   // -------------------------------------------------------------------------
   // Slot counter and FIFO pop
   // -------------------------------------------------------------------------

   // Pop when idle, or while loading the last word so frames run back to back
   assign rd_en_o = link_up_i & ~empty_i & (~run_q | (slot_q == LAST_SLOT));

   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         run_q  <= 1'b0;
         slot_q <= '0;
      end else if (!link_up_i) begin
         run_q  <= 1'b0;                       // Abandon a frame in progress
         slot_q <= '0;
      end else if (rd_en_o) begin
         run_q  <= 1'b1;                       // Bundle on rd_data_i next cycle
         slot_q <= '0;
      end else if (run_q) begin
         slot_q <= slot_q + 1'b1;
         if (slot_q == LAST_SLOT) run_q <= 1'b0;
      end
   end

   // Separator priority
   always_comb begin
      if (rd_data_i.bc0)
         sep = gem_tx_pkg::K_BC0;
      else if (rd_data_i.resync)
         sep = gem_tx_pkg::K_RESYNC;
      else if (rd_data_i.overflow)
         sep = gem_tx_pkg::K_OVERFLOW;
      else
         sep = gem_tx_pkg::K_SEQ[rd_data_i.bxn_lsbs];   // BX rotation
   end

   // -------------------------------------------------------------------------
   // Per-link slicing and output word registers
   // -------------------------------------------------------------------------

   for (genvar n = 0; n < N_LINKS; n++) begin : g_link
      logic [gem_tx_pkg::LINK_DATA_BITS-1:0] d;     // This link's cluster slice
      gem_tx_pkg::link_word_t                word_q;

      assign d = rd_data_i.clusters[n*gem_tx_pkg::LINK_DATA_BITS +: gem_tx_pkg::LINK_DATA_BITS];
      assign tx_words_o[n] = word_q;

      always_ff @(posedge clock_40 or negedge rst_n_i) begin
         if (!rst_n_i) begin
            word_q <= gem_tx_pkg::IDLE_WORD;
         end else if (!link_up_i || !run_q) begin
            word_q <= gem_tx_pkg::IDLE_WORD;   // Comma filler
         end else begin
            case (slot_q)
               2'd0:    word_q <= '{data: {d[7:0], sep}, isk: 2'b01};  // K-code in low byte
               2'd1:    word_q <= '{data: d[23:8],  isk: 2'b00};
               2'd2:    word_q <= '{data: d[39:24], isk: 2'b00};
               default: word_q <= '{data: d[55:40], isk: 2'b00};
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/ready_timer.sv
`timescale 1ns/1ps
`default_nettype none

module ready_timer #(
   parameter int READY_HOLD = 16
) (
   input  wire  clock_40,
   input  wire  rst_n_i,
   input  wire  link_up_i,
   input  wire  force_not_ready_i,
   output logic ready_o
);

   localparam int CNT_W = $clog2(READY_HOLD + 1);

   logic [CNT_W-1:0] cnt_q;   // Consecutive good cycles, saturates at hold

   always_ff @(posedge clock_40 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (!link_up_i || force_not_ready_i) begin
         cnt_q <= '0;                          // Restart the hold time
      end else if (cnt_q != CNT_W'(READY_HOLD)) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign ready_o = (cnt_q == CNT_W'(READY_HOLD));

endmodule

`default_nettype wire

// File: logic/gem_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module gem_tx_top #(
   parameter int N_LINKS    = 2,
   parameter int FIFO_DEPTH = 8,
   parameter int READY_HOLD = 16
) (
   input  wire                       clock_40,
   input  wire                       rst_n_i,
   input  wire gem_tx_pkg::trig_bundle_t bundle_i,
   input  wire                       bundle_valid_i,
   output wire                       bundle_ready_o,
   input  wire                       link_up_i,          // Transmitter reset done
   input  wire                       force_not_ready_i,
   output wire gem_tx_pkg::link_word_t [N_LINKS-1:0] tx_words_o,
   output wire                       ready_o
);

   // -------------------------------------------------------------------------
   // Capture to FIFO to framer
   // -------------------------------------------------------------------------

   gem_tx_pkg::trig_bundle_t push;      // Capture stage to FIFO
   gem_tx_pkg::trig_bundle_t rd_data;   // FIFO to framer
   wire                      wr_en;
   wire                      full;
   wire                      rd_en;
   wire                      empty;

   cluster_capture i_cluster_capture (
      .clock_40       (clock_40),
      .rst_n_i        (rst_n_i),
      .bundle_i       (bundle_i),
      .bundle_valid_i (bundle_valid_i),
      .bundle_ready_o (bundle_ready_o),
      .link_up_i      (link_up_i),
      .full_i         (full),
      .push_o         (push),
      .wr_en_o        (wr_en)
   );

   bundle_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_bundle_fifo (
      .clock_40  (clock_40),
      .rst_n_i   (rst_n_i),
      .wr_en_i   (wr_en),
      .wr_data_i (push),
      .full_o    (full),
      .rd_en_i   (rd_en),
      .rd_data_o (rd_data),
      .empty_o   (empty)
   );

   link_framer #(.N_LINKS(N_LINKS)) i_link_framer (
      .clock_40   (clock_40),
      .rst_n_i    (rst_n_i),
      .link_up_i  (link_up_i),
      .empty_i    (empty),
      .rd_en_o    (rd_en),
      .rd_data_i  (rd_data),
      .tx_words_o (tx_words_o)
   );

   // Link readiness, independent of the data path
   ready_timer #(.READY_HOLD(READY_HOLD)) i_ready_timer (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .link_up_i         (link_up_i),
      .force_not_ready_i (force_not_ready_i),
      .ready_o           (ready_o)
   );

endmodule

`default_nettype wire

// File: sim/gem_tx_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module gem_tx_assertions (
   input wire clock_40,
   input wire rst_n_i,
   input wire link_up_i,
   input wire empty_i,
   input wire rd_en_i      // Framer pop
);

   int fail_count = 0;   // Failed assertions, read at the end of the run

   // Never pop an empty FIFO
   a_no_pop_when_empty: assert property (@(posedge clock_40) disable iff (!rst_n_i)
      empty_i |-> !rd_en_i)
      else begin
         fail_count++;
         $error("FIFO popped while empty");
      end

   // No frame starts with the link down
   a_no_pop_link_down: assert property (@(posedge clock_40) disable iff (!rst_n_i)
      !link_up_i |-> !rd_en_i)
      else begin
         fail_count++;
         $error("FIFO popped with the link down");
      end

endmodule

bind link_framer gem_tx_assertions i_framer_assertions (
   .clock_40  (clock_40),
   .rst_n_i   (rst_n_i),
   .link_up_i (link_up_i),
   .empty_i   (empty_i),
   .rd_en_i   (rd_en_o)
);

`default_nettype wire

// File: sim/gem_tx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module gem_tx_checker #(
   parameter int N_LINKS    = 2,
   parameter int READY_HOLD = 16
) (
   input  wire                                       clock_40,
   input  wire                                       rst_n_i,
   input  wire gem_tx_pkg::trig_bundle_t             bundle_i,
   input  wire                                       bundle_valid_i,
   input  wire                                       bundle_ready_i,
   input  wire                                       link_up_i,
   input  wire                                       force_not_ready_i,
   input  wire gem_tx_pkg::link_word_t [N_LINKS-1:0] tx_words_i,
   input  wire                                       ready_i,
   input  wire                                       report_i,     // End of a test
   input  wire [7:0]                                 test_num_i,
   output int                                        errors_o,
   output int                                        checks_o,
   output logic                                      drained_o     // Every frame seen
);

   localparam logic [17:0] IDLE = {16'hFFFC, 2'b01};   // Comma filler, K in low byte

   gem_tx_pkg::trig_bundle_t expect_q [$];   // Accepted, frame not yet started
   gem_tx_pkg::trig_bundle_t cur;            // Bundle of the running frame
   int   slot;          // Next word of the frame, 0 between frames
   int   good_cycles;   // Ready hold model
   logic link_prev;     // Link state seen by the last edge
   int   test_frames;
   int   test_errors;

   // Separator priority bc0, resync, overflow, then BX rotation
   function automatic logic [7:0] separator(input gem_tx_pkg::trig_bundle_t b);
      if (b.bc0) return 8'h1C;
      if (b.resync) return 8'h3C;
      if (b.overflow) return 8'hFE;
      case (b.bxn_lsbs)
         2'd0:    return 8'hBC;
         2'd1:    return 8'hF7;
         2'd2:    return 8'hFB;
         default: return 8'hFD;
      endcase
   endfunction

   function automatic logic [17:0] frame_word(input gem_tx_pkg::trig_bundle_t b,
                                              input int link, input int k);
      logic [55:0] d;
      d = b.clusters[link*56 +: 56];                       // This link's slice
      case (k)
         0:       return {d[7:0], separator(b), 2'b01};
         1:       return {d[23:8], 2'b00};
         2:       return {d[39:24], 2'b00};
         default: return {d[55:40], 2'b00};
      endcase
   endfunction

   task automatic flag(input string msg);
      errors_o++;
      test_errors++;
      $display("** Error (%0t): %s", $time, msg);
   endtask

   task automatic compare_word(input int link, input int k, input logic [17:0] got,
                               input logic [17:0] exp);
      checks_o++;
      if (got !== exp)
         flag($sformatf("link %0d word %0d got %h expected %h", link, k, got, exp));
   endtask

   // ------------------------------------------------------------------------
   // Sampled on the falling edge, all ports settled
   // ------------------------------------------------------------------------

   always @(negedge clock_40) begin
      if (!rst_n_i) begin
         expect_q.delete();
         slot        = 0;
         good_cycles = 0;
         link_prev   = 1'b0;
         test_frames = 0;
         test_errors = 0;
         errors_o    = 0;
         checks_o    = 0;
      end else begin
         checks_o++;
         if (ready_i !== (good_cycles >= READY_HOLD))
            flag($sformatf("ready_o is %b after %0d good cycles", ready_i, good_cycles));
         if (!link_up_i && bundle_ready_i !== 1'b0)
            flag("bundle_ready_o high with the link down");
         if (!link_prev) begin
            slot = 0;                                     // Link down, idle only
            for (int n = 0; n < N_LINKS; n++) compare_word(n, 0, tx_words_i[n], IDLE);
         end else if (slot != 0) begin
            for (int n = 0; n < N_LINKS; n++)
               compare_word(n, slot, tx_words_i[n], frame_word(cur, n, slot));
            slot = (slot + 1) % 4;
         end else if (tx_words_i[0].isk == 2'b01 && tx_words_i[0].data[7:0] != 8'hFC) begin
            if (expect_q.size() == 0) begin
               flag("frame started with no bundle pending");
            end else begin
               cur = expect_q.pop_front();                // Oldest accepted bundle
               for (int n = 0; n < N_LINKS; n++)
                  compare_word(n, 0, tx_words_i[n], frame_word(cur, n, 0));
               test_frames++;
               slot = 1;
            end
         end else begin
            for (int n = 0; n < N_LINKS; n++) compare_word(n, 0, tx_words_i[n], IDLE);
         end
         if (bundle_valid_i && bundle_ready_i) expect_q.push_back(bundle_i);  // Next edge
         if (link_up_i && !force_not_ready_i)
            good_cycles = (good_cycles >= READY_HOLD) ? READY_HOLD : good_cycles + 1;
         else
            good_cycles = 0;
         link_prev = link_up_i;
         if (report_i) begin
            $display("test %0d: %0d frames, %0d errors", test_num_i, test_frames, test_errors);
            test_frames = 0;
            test_errors = 0;
         end
      end
      drained_o = (expect_q.size() == 0) && (slot == 0);
   end

endmodule

`default_nettype wire

// File: sim/tb_gem_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gem_tx;

   localparam int N_LINKS    = 2;
   localparam int READY_HOLD = 16;
   localparam int N_ROWS     = 11;

   typedef struct packed {
      logic       link_up;
      logic       force_nr;
      logic       bc0;
      logic       resync;
      logic       overflow;
      logic [1:0] bxn;         // BX bits of the first bundle, counting up
      logic [7:0] burst;       // Bundles in the row
      logic       exp_ready;
   } row_t;

   logic                                 clock_40 = 1'b0;
   logic                                 rst_n_i;
   gem_tx_pkg::trig_bundle_t             bundle;
   logic                                 bundle_valid;
   logic                                 link_up;
   logic                                 force_nr;
   logic                                 report;          // Closes a test in the checker
   logic [7:0]                           test_num;
   wire                                  bundle_ready;
   wire                                  ready;
   wire gem_tx_pkg::link_word_t [N_LINKS-1:0] tx_words;
   int                                   errors;
   int                                   checks;
   logic                                 drained;
   row_t                                 rows [N_ROWS];
   logic [31:0]                          lfsr = 32'h7878;
   int                                   tb_errors = 0;
   int                                   stalls;          // Cycles with valid but no ready
   logic                                 ok = 1'b1;

   always #10 clock_40 = ~clock_40;                       // 20 ns period

   gem_tx_top #(
      .N_LINKS    (N_LINKS),
      .FIFO_DEPTH (8),
      .READY_HOLD (READY_HOLD)
   ) i_gem_tx_top (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .bundle_i          (bundle),
      .bundle_valid_i    (bundle_valid),
      .bundle_ready_o    (bundle_ready),
      .link_up_i         (link_up),
      .force_not_ready_i (force_nr),
      .tx_words_o        (tx_words),
      .ready_o           (ready)
   );

   gem_tx_checker #(.N_LINKS(N_LINKS), .READY_HOLD(READY_HOLD)) i_checker (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .bundle_i          (bundle),
      .bundle_valid_i    (bundle_valid),
      .bundle_ready_i    (bundle_ready),
      .link_up_i         (link_up),
      .force_not_ready_i (force_nr),
      .tx_words_i        (tx_words),
      .ready_i           (ready),
      .report_i          (report),
      .test_num_i        (test_num),
      .errors_o          (errors),
      .checks_o          (checks),
      .drained_o         (drained)
   );

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic load_table();
      //         link  force bc0   rsync ovf   bxn   burst  ready
      rows[0]  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 8'd0,  1'b0};  // Down after reset
      rows[1]  = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 8'd4,  1'b1};  // BX rotation 0..3
      rows[2]  = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd1, 8'd2,  1'b1};  // bc0 alone
      rows[3]  = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 2'd2, 8'd2,  1'b1};  // bc0 over resync
      rows[4]  = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 2'd3, 8'd2,  1'b1};  // resync alone
      rows[5]  = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 2'd0, 8'd2,  1'b1};  // overflow alone
      rows[6]  = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1, 8'd20, 1'b1};  // Fills the FIFO
      rows[7]  = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2'd2, 8'd2,  1'b0};  // Forced not ready
      rows[8]  = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd3, 8'd1,  1'b1};  // Released
      rows[9]  = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 8'd0,  1'b0};  // Link drop, FIFO empty
      rows[10] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 2'd2, 8'd3,  1'b1};  // Resumes framing
   endtask

   // 112 cluster bits, one LFSR step per bit
   task automatic make_bundle(input row_t r, input int i);
      gem_tx_pkg::trig_bundle_t b;
      for (int k = 0; k < 112; k++) begin
         lfsr = lfsr_next(lfsr);
         b.clusters[k] = lfsr[0];
      end
      b.overflow = r.overflow;
      b.bc0      = r.bc0;
      b.resync   = r.resync;
      b.bxn_lsbs = r.bxn + 2'(i);
      bundle <= b;
   endtask

   task automatic send_burst(input row_t r, input int t, output logic sent_ok);
      int   wait_cnt;
      logic accepted;
      sent_ok = 1'b1;
      stalls  = 0;
      for (int i = 0; i < int'(r.burst) && sent_ok; i++) begin
         make_bundle(r, i);
         bundle_valid <= 1'b1;
         wait_cnt = 0;
         do begin
            @(negedge clock_40);
            accepted = bundle_ready;                     // Handshake at the coming edge
            if (!accepted) stalls++;
            wait_cnt++;
            @(posedge clock_40);
         end while (!accepted && wait_cnt < 50);
         if (!accepted) begin
            $display("Timeout: bundle %0d of test %0d was never accepted", i, t);
            sent_ok = 1'b0;
         end
      end
      bundle_valid <= 1'b0;
   endtask

   task automatic wait_drained(input int t, output logic done_ok);
      int wait_cnt;
      wait_cnt = 0;
      while (!drained && wait_cnt < 100) begin
         @(posedge clock_40);
         wait_cnt++;
      end
      done_ok = drained;
      if (!done_ok) $display("Timeout: frames of test %0d did not all come out", t);
   endtask

   task automatic wait_ready(input logic exp, input int t, output logic done_ok);
      int wait_cnt;
      wait_cnt = 0;
      @(negedge clock_40);                                // ready_o settled here
      while (ready !== exp && wait_cnt < READY_HOLD + 8) begin
         @(negedge clock_40);
         wait_cnt++;
      end
      done_ok = (ready === exp);
      if (!done_ok) $display("Timeout: ready_o did not become %b in test %0d", exp, t);
      @(posedge clock_40);                                // Back onto the drive edge
   endtask

   task automatic run_row(input int t, output logic row_ok);
      row_t r;
      r        = rows[t];
      row_ok   = 1'b1;
      test_num <= 8'(t);
      link_up  <= r.link_up;
      force_nr <= r.force_nr;
      if (r.burst != 8'd0) send_burst(r, t, row_ok);
      if (row_ok) wait_drained(t, row_ok);
      if (row_ok && r.burst >= 8'd12 && stalls == 0) begin
         tb_errors++;
         $display("** Error (%0t): test %0d never saw bundle_ready_o low", $time, t);
      end
      if (row_ok) wait_ready(r.exp_ready, t, row_ok);
      if (!r.link_up) repeat (3) @(posedge clock_40);   // Keep the link down a while
      report <= 1'b1;
      @(posedge clock_40);
      report <= 1'b0;
   endtask

   initial begin
      load_table();
      rst_n_i      <= 1'b0;
      bundle       <= '0;
      bundle_valid <= 1'b0;
      link_up      <= 1'b0;
      force_nr     <= 1'b0;
      report       <= 1'b0;
      test_num     <= 8'd0;
      repeat (4) @(posedge clock_40);
      rst_n_i <= 1'b1;
      @(posedge clock_40);
      for (int t = 0; t < N_ROWS && ok; t++) run_row(t, ok);
      repeat (2) @(posedge clock_40);
      $display("%0d checks, %0d errors, %0d assertion failures", checks, errors + tb_errors,
               i_gem_tx_top.i_link_framer.i_framer_assertions.fail_count);
      if (ok && errors == 0 && tb_errors == 0 &&
          i_gem_tx_top.i_link_framer.i_framer_assertions.fail_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
common/gem_tx_pkg.sv
logic/cluster_capture.sv
bundle_fifo/bundle_fifo.sv
link_framer/link_framer.sv
logic/ready_timer.sv
logic/gem_tx_top.sv
sim/gem_tx_assertions.sv
sim/gem_tx_checker.sv
sim/tb_gem_tx.sv

// File: Makefile
SRCS := $(shell cat compile.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_gem_tx: compile.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_gem_tx -f compile.f

run: obj_dir/Vtb_gem_tx
	@out="$$(./obj_dir/Vtb_gem_tx +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
